// File: design/video_pkg.sv
`default_nettype none

package video_pkg;

	typedef logic [8:0]  hcount_t;  // pixel position within a line
	typedef logic [8:0]  vcount_t;  // line number within a frame
	typedef logic [15:0] wb_data_t; // wishbone data word
	typedef logic [1:0]  wb_addr_t; // wishbone register address

	// horizontal events and windows, in hcount units
	localparam hcount_t HSYNC_BEG = 9'd8;   // hsync_start
	localparam hcount_t HSYNC_END = 9'd40;  // line_start, ends hsync
	localparam hcount_t HBLNK_END = 9'd64;
	localparam hcount_t HPIX_BEG  = 9'd104;
	localparam hcount_t HPIX_END  = 9'd360; // 256 pixels

	// vertical positions, in lines
	localparam vcount_t VBLNK_BEG = 9'd0;
	localparam vcount_t VSYNC_BEG = 9'd8;
	localparam vcount_t VSYNC_END = 9'd11;
	localparam vcount_t VBLNK_END = 9'd32;  // also the pre_vline line
	localparam vcount_t VPIX_BEG  = 9'd80;
	localparam vcount_t VPIX_END  = 9'd272; // 192 picture lines

	localparam vcount_t SRELOAD_LINE = 9'd134; // VBLNK_END + 102
	localparam vcount_t INT_LINE     = 9'd0;

	// z80 INT is held low this many clocks
	localparam int INT_LEN = 32;

	// register map
	localparam wb_addr_t REG_CTRL  = 2'd0; // bit 0 int_en
	localparam wb_addr_t REG_HINT  = 2'd1; // interrupt position in the line
	localparam wb_addr_t REG_STAT  = 2'd2; // vblank, vsync, pending
	localparam wb_addr_t REG_FRAME = 2'd3; // fired interrupt count

endpackage

`default_nettype wire

// File: design/wb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module wb_regs (
	input  wire                 clk,
	input  wire                 arst_n,

	// wishbone classic slave
	input  wire                 wb_cyc,
	input  wire                 wb_stb,
	input  wire                 wb_we,
	input  wire video_pkg::wb_addr_t wb_adr,
	input  wire video_pkg::wb_data_t wb_dat_w,
	output video_pkg::wb_data_t wb_dat_r,
	output logic                wb_ack,

	output logic                int_en,    // to video_out
	output video_pkg::hcount_t  hint_pos,  // to sync_h
	input  wire                 int_fired, // one clock, int_n just fell
	input  wire                 vblank,
	input  wire                 vsync
);

	import video_pkg::*;

	logic     acc;       // new access seen, ack goes high next clock
	logic     wr;        // write strobe, lands on the ack edge
	logic     pend;      // interrupt pending flag
	wb_data_t frame_cnt; // fired interrupts since last clear

	assign acc = wb_cyc && wb_stb && !wb_ack;
	assign wr  = acc && wb_we;

	// single wait state then one clock of ack
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= acc;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			int_en   <= 1'b0;
			hint_pos <= '0;
		end
		else
		begin
			if (wr && (wb_adr == REG_CTRL))
				int_en <= wb_dat_w[0];
			if (wr && (wb_adr == REG_HINT))
				hint_pos <= wb_dat_w[8:0]; // upper bits ignored
		end
	end

	// a set from int_fired beats a clear in the same clock
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pend <= 1'b0;
		else if (int_fired)
			pend <= 1'b1;
		else if (wr && (wb_adr == REG_STAT) && wb_dat_w[2])
			pend <= 1'b0; // write 1 to clear
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			frame_cnt <= '0;
		else if (wr && (wb_adr == REG_FRAME))
			frame_cnt <= {15'd0, int_fired}; // clear, keep a coincident count
		else if (int_fired)
			frame_cnt <= frame_cnt + 16'd1;
	end

	// read mux, master holds adr so data is stable while ack is high
	always_comb
	begin
		case (wb_adr)
			REG_CTRL:  wb_dat_r = {15'd0, int_en};
			REG_HINT:  wb_dat_r = {7'd0, hint_pos};
			REG_STAT:  wb_dat_r = {13'd0, pend, vsync, vblank};
			REG_FRAME: wb_dat_r = frame_cnt;
			default:   wb_dat_r = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/sync_h.sv
`timescale 1ns/100ps
`default_nettype none

// horizontal counter, all outputs are registered decodes of hcount
// so every event lags its hcount position by one clock
module sync_h #(
	parameter int h_total = 448 // clocks per line, must exceed HPIX_END
) (
	input  wire                     clk,
	input  wire                     arst_n,

	input  wire video_pkg::hcount_t hint_pos, // where the interrupt fires

	output logic                    hsync_start, // one clock pulses
	output logic                    line_start,
	output logic                    hint_start,

	output logic                    hblank, // levels
	output logic                    hpix
);

	import video_pkg::*;

	hcount_t hcount; // pixel position in the line

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			hcount <= '0;
		else if (hcount == hcount_t'(h_total - 1))
			hcount <= '0; // end of line
		else
			hcount <= hcount + 9'd1;
	end

	// line events
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hsync_start <= 1'b0;
			line_start  <= 1'b0;
			hint_start  <= 1'b0;
		end
		else
		begin
			hsync_start <= (hcount == HSYNC_BEG);
			line_start  <= (hcount == HSYNC_END); // also ends hsync
			hint_start  <= (hcount == hint_pos);  // never fires if hint_pos >= h_total
		end
	end

	// horizontal windows
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hblank <= 1'b0;
			hpix   <= 1'b0;
		end
		else
		begin
			hblank <= (hcount < HBLNK_END);
			hpix   <= (hcount >= HPIX_BEG) && (hcount < HPIX_END);
		end
	end

endmodule

`default_nettype wire

// File: design/sync_v.sv
`timescale 1ns/100ps
`default_nettype none

// vertical blank, sync and picture window
// lines are counted on hsync_start, flags compare the count before the step
module sync_v #(
	parameter int v_total = 320 // lines per frame, must exceed VPIX_END
) (
	input  wire  clk,
	input  wire  arst_n,

	input  wire  hsync_start, // line counter step
	input  wire  line_start,  // ends vsync, times the line markers
	input  wire  hint_start,

	output logic vblank,
	output logic vsync,
	output logic vpix,      // line carries pixels, not only border
	output logic pre_vline, // first line after vblank
	output logic s_reload,  // screen reload line
	output logic int_start  // one clock, start of z80 INT
);

	import video_pkg::*;

	vcount_t vcount;     // current line
	vcount_t vcount_nxt; // line after the coming hsync_start
	vcount_t line_now;   // line the current clock belongs to

	assign vcount_nxt = (vcount == vcount_t'(v_total - 1)) ? '0 : vcount + 9'd1;

	// hint_start on the same clock as hsync_start already belongs to the new line
	assign line_now = hsync_start ? vcount_nxt : vcount;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			vcount <= '0;
		else if (hsync_start)
			vcount <= vcount_nxt;
	end

	// vblank and vpix move with the hsync edge
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			vblank <= 1'b0;
			vpix   <= 1'b0;
		end
		else if (hsync_start)
		begin
			if (vcount == VBLNK_BEG)
				vblank <= 1'b1;
			else if (vcount == VBLNK_END)
				vblank <= 1'b0;

			if (vcount == VPIX_BEG)
				vpix <= 1'b1;
			else if (vcount == VPIX_END)
				vpix <= 1'b0;
		end
	end

	// vsync ends some time after hsync, on line_start
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			vsync <= 1'b0;
		else if (hsync_start && (vcount == VSYNC_BEG))
			vsync <= 1'b1;
		else if (line_start && (vcount == VSYNC_END))
			vsync <= 1'b0;
	end

	// markers are rewritten every line, so each lasts exactly one line
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pre_vline <= 1'b0;
			s_reload  <= 1'b0;
		end
		else if (line_start)
		begin
			pre_vline <= (vcount == VBLNK_END);
			s_reload  <= (vcount == SRELOAD_LINE);
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			int_start <= 1'b0;
		else
			int_start <= hint_start && (line_now == INT_LINE); // once per frame
	end

endmodule

`default_nettype wire

// File: design/video_out.sv
`timescale 1ns/100ps
`default_nettype none

module video_out (
	input  wire  clk,
	input  wire  arst_n,

	input  wire  hsync_start,
	input  wire  line_start,
	input  wire  hblank,
	input  wire  hpix,
	input  wire  vblank,
	input  wire  vsync,
	input  wire  vpix,
	input  wire  int_start,
	input  wire  int_en,

	output logic hsync,
	output logic vsync_o,
	output logic blank,
	output logic pix_en,
	output logic int_n,    // active low z80 INT
	output logic int_fired // one clock, first clock of int_n low
);

	import video_pkg::*;

	localparam int CNT_W = $clog2(INT_LEN);

	logic [CNT_W-1:0] int_cnt; // clocks of int_n low still to go

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hsync   <= 1'b0;
			vsync_o <= 1'b0;
			blank   <= 1'b0;
			pix_en  <= 1'b0;
		end
		else
		begin
			if (hsync_start)
				hsync <= 1'b1; // high from hsync_start to line_start
			else if (line_start)
				hsync <= 1'b0;
			vsync_o <= vsync;
			blank   <= hblank || vblank;
			pix_en  <= hpix && vpix;
		end
	end

	// int stretcher, retrigger while low is ignored
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			int_n     <= 1'b1;
			int_fired <= 1'b0;
			int_cnt   <= '0;
		end
		else
		begin
			int_fired <= 1'b0;
			if (int_n)
			begin
				if (int_start && int_en)
				begin
					int_n     <= 1'b0;
					int_fired <= 1'b1;
					int_cnt   <= CNT_W'(INT_LEN - 1);
				end
			end
			else if (int_cnt == '0)
				int_n <= 1'b1; // INT_LEN clocks done
			else
				int_cnt <= int_cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/video_top.sv
`timescale 1ns/100ps
`default_nettype none

module video_top #(
	parameter int h_total = 448, // clocks per line
	parameter int v_total = 320  // lines per frame
) (
	input  wire                      clk,
	input  wire                      arst_n,

	// wishbone classic slave
	input  wire                      wb_cyc,
	input  wire                      wb_stb,
	input  wire                      wb_we,
	input  wire video_pkg::wb_addr_t wb_adr,
	input  wire video_pkg::wb_data_t wb_dat_w,
	output video_pkg::wb_data_t      wb_dat_r,
	output logic                     wb_ack,

	// video
	output logic                     hsync,
	output logic                     vsync,
	output logic                     blank,
	output logic                     pix_en,
	output logic                     int_n,
	output logic                     pre_vline, // for pixel fetch
	output logic                     s_reload
);

	import video_pkg::*;

	logic    int_en;
	hcount_t hint_pos;
	logic    int_fired;

	// horizontal events
	logic    hsync_start;
	logic    line_start;
	logic    hint_start;
	logic    hblank;
	logic    hpix;

	// vertical levels, vsync_v is before the output register
	logic    vblank;
	logic    vsync_v;
	logic    vpix;
	logic    int_start;

	wb_regs u_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.int_en    (int_en),
		.hint_pos  (hint_pos),
		.int_fired (int_fired),
		.vblank    (vblank),
		.vsync     (vsync_v)
	);

	sync_h #(.h_total(h_total)) u_sync_h (
		.clk         (clk),
		.arst_n      (arst_n),
		.hint_pos    (hint_pos),
		.hsync_start (hsync_start),
		.line_start  (line_start),
		.hint_start  (hint_start),
		.hblank      (hblank),
		.hpix        (hpix)
	);

	sync_v #(.v_total(v_total)) u_sync_v (
		.clk         (clk),
		.arst_n      (arst_n),
		.hsync_start (hsync_start),
		.line_start  (line_start),
		.hint_start  (hint_start),
		.vblank      (vblank),
		.vsync       (vsync_v),
		.vpix        (vpix),
		.pre_vline   (pre_vline),
		.s_reload    (s_reload),
		.int_start   (int_start)
	);

	video_out u_out (
		.clk         (clk),
		.arst_n      (arst_n),
		.hsync_start (hsync_start),
		.line_start  (line_start),
		.hblank      (hblank),
		.hpix        (hpix),
		.vblank      (vblank),
		.vsync       (vsync_v),
		.vpix        (vpix),
		.int_start   (int_start),
		.int_en      (int_en),
		.hsync       (hsync),
		.vsync_o     (vsync),
		.blank       (blank),
		.pix_en      (pix_en),
		.int_n       (int_n),
		.int_fired   (int_fired)
	);

endmodule

`default_nettype wire

// File: sim/tb_video.sv
`timescale 1ns/100ps
`default_nettype none

module tb_video;

	import video_pkg::*;

	localparam int h_total   = 448;
	localparam int v_total   = 320;
	localparam int wd_clocks = 4 * h_total * v_total + 20000; // four frames and some slack

	logic     clk;
	logic     arst_n;
	logic     wb_cyc;
	logic     wb_stb;
	logic     wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic     wb_ack;
	logic     hsync;
	logic     vsync;
	logic     blank;
	logic     pix_en;
	logic     int_n;
	logic     pre_vline;
	logic     s_reload;

	int          err_cnt = 0;
	int          chk_cnt = 0;
	int          hint    = 0; // hint_pos in use
	logic [31:0] rng     = 32'he070_4026;

	// monitor state, written only by the monitor block
	longint clk_cnt = 0;
	longint hs_last = -1;
	longint pe_last = 0;
	longint vs_last = 0;
	longint pv_last = -1;
	longint sr_last = 0;
	longint in_last = -1; // last int_n fall
	int     hs_rises = 0;
	int     pix_lines = 0;
	int     blank_lines = 0;
	int     pv_rises = 0;
	int     sr_rises = 0;
	int     pv_lines = 0;  // hsync rises since pre_vline rose
	int     frames = 0;    // vsync rises seen
	int     fall_cnt = 0;  // int_n falls seen
	logic   line_pix = 0;
	logic   line_blank = 0;
	logic   hs_q = 0;
	logic   pe_q = 0;
	logic   vs_q = 0;
	logic   pv_q = 0;
	logic   sr_q = 0;
	logic   in_q = 1;

	video_top #(.h_total(h_total), .v_total(v_total)) DUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.hsync     (hsync),
		.vsync     (vsync),
		.blank     (blank),
		.pix_en    (pix_en),
		.int_n     (int_n),
		.pre_vline (pre_vline),
		.s_reload  (s_reload)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_val(input string name, input longint exp, input longint act);
		chk_cnt++;
		assert (act == exp)
		else
		begin
			err_cnt++;
			$display("ERROR %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	// ack must come exactly one clock after stb is seen
	task automatic await_ack(input string name);
		int waited;
		@(posedge clk); // stb sampled here
		waited = 0;
		while (!wb_ack && waited < 16)
		begin
			@(posedge clk);
			waited++;
		end
		if (!wb_ack)
		begin
			err_cnt++;
			$display("%s got no ack from the register slave", name);
		end
		else
			check_val(name, 1, waited);
	endtask

	task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		await_ack("write ack delay");
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b0;
		wb_adr <= adr;
		await_ack("read ack delay");
		dat = wb_dat_r; // valid while ack is high
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	ack_single: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack)
	else
	begin
		err_cnt++;
		$display("ERROR ack_single expected 0 actual 1");
	end

	ack_follows_stb: assert property (@(posedge clk) disable iff (!arst_n)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
	else
	begin
		err_cnt++;
		$display("ERROR ack_follows_stb expected 1 actual 0");
	end

	// timing monitor, samples the values held before each edge
	always @(posedge clk)
	begin
		if (arst_n)
		begin
			clk_cnt++;
			if (hsync && !hs_q)
			begin
				if (hs_last >= 0)
					check_val("hsync period", h_total, clk_cnt - hs_last);
				hs_last = clk_cnt;
				hs_rises++;
				pv_lines++;
				if (line_pix)
					pix_lines++;
				if (line_blank)
					blank_lines++;
				line_pix   = 1'b0; // new line starts here
				line_blank = 1'b1;
			end
			if (!hsync && hs_q)
				check_val("hsync width", int'(HSYNC_END - HSYNC_BEG), clk_cnt - hs_last);
			line_pix   = line_pix | pix_en;
			line_blank = line_blank & blank;

			if (pix_en && !pe_q)
				pe_last = clk_cnt;
			if (!pix_en && pe_q)
				check_val("pix_en run", int'(HPIX_END - HPIX_BEG), clk_cnt - pe_last);

			if (vsync && !vs_q)
			begin
				if (frames > 0) // first window after reset is partial
				begin
					check_val("lines per frame", v_total, hs_rises);
					check_val("picture lines", int'(VPIX_END - VPIX_BEG), pix_lines);
					check_val("blank lines", int'(VBLNK_END), blank_lines);
					check_val("pre_vline per frame", 1, pv_rises);
					check_val("s_reload per frame", 1, sr_rises);
				end
				hs_rises    = 0;
				pix_lines   = 0;
				blank_lines = 0;
				pv_rises    = 0;
				sr_rises    = 0;
				frames++;
				vs_last = clk_cnt;
			end
			// rises on the hsync that ends line VSYNC_BEG, falls on line_start of line VSYNC_END
			if (!vsync && vs_q)
				check_val("vsync width", (int'(VSYNC_END - VSYNC_BEG) - 1) * h_total
					+ int'(HSYNC_END - HSYNC_BEG), clk_cnt - vs_last);

			if (pre_vline && !pv_q)
			begin
				pv_rises++;
				pv_lines = 0;
				pv_last  = clk_cnt;
			end
			if (!pre_vline && pv_q)
				check_val("pre_vline width", h_total, clk_cnt - pv_last);
			if (s_reload && !sr_q)
			begin
				sr_rises++;
				sr_last = clk_cnt;
				if (pv_last >= 0)
					check_val("pre_vline to s_reload", int'(SRELOAD_LINE - VBLNK_END), pv_lines);
			end
			if (!s_reload && sr_q)
				check_val("s_reload width", h_total, clk_cnt - sr_last);

			if (!int_n && in_q)
			begin
				fall_cnt++;
				check_val("int offset", ((hint - int'(HSYNC_BEG) + h_total) % h_total + 1)
					% h_total, (clk_cnt - hs_last) % h_total);
				if (in_last >= 0)
					check_val("int period", h_total * v_total, clk_cnt - in_last);
				in_last = clk_cnt;
			end
			if (int_n && !in_q)
				check_val("int width", INT_LEN, clk_cnt - in_last);

			hs_q = hsync;
			pe_q = pix_en;
			vs_q = vsync;
			pv_q = pre_vline;
			sr_q = s_reload;
			in_q = int_n;
		end
	end

	initial
	begin : main
		wb_data_t rd;
		int       base;
		arst_n   = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		repeat (4) @(posedge clk);
		check_val("reset hsync", 0, hsync);
		check_val("reset vsync", 0, vsync);
		check_val("reset blank", 0, blank);
		check_val("reset pix_en", 0, pix_en);
		check_val("reset pre_vline", 0, pre_vline);
		check_val("reset s_reload", 0, s_reload);
		check_val("reset wb_ack", 0, wb_ack);
		check_val("reset int_n", 1, int_n);
		arst_n <= 1'b1;
		@(posedge clk);

		// register read back
		wb_write(REG_CTRL, 16'h0000);
		wb_read(REG_CTRL, rd);
		check_val("ctrl readback", 0, rd);
		wb_write(REG_HINT, 16'h00ab);
		wb_read(REG_HINT, rd);
		check_val("hint readback", 16'h00ab, rd);

		// interrupt at a random position in the line
		rng  = xorshift32(rng);
		hint = int'(rng % 32'(h_total));
		wb_write(REG_HINT, wb_data_t'(hint));
		wb_write(REG_FRAME, 16'h0000);
		wb_write(REG_CTRL, 16'h0001);
		wb_read(REG_CTRL, rd);
		check_val("ctrl enable readback", 1, rd);
		while (fall_cnt < 2)
			@(posedge clk); // watchdog bounds this wait
		while (!int_n)
			@(posedge clk);
		repeat (2) @(posedge clk);
		wb_read(REG_FRAME, rd);
		check_val("frame count", fall_cnt, rd);
		wb_read(REG_STAT, rd);
		check_val("stat pending set", 1, rd[2]);
		wb_write(REG_STAT, 16'h0004); // write 1 clears
		wb_read(REG_STAT, rd);
		check_val("stat pending clear", 0, rd[2]);
		wb_write(REG_FRAME, 16'h1234);
		wb_read(REG_FRAME, rd);
		check_val("frame count clear", 0, rd);

		// disabled, a whole frame passes with int_n high
		wb_write(REG_CTRL, 16'h0000);
		base = fall_cnt;
		begin : idle
			int f0;
			f0 = frames;
			while (frames == f0)
				@(posedge clk);
			wb_read(REG_STAT, rd); // vsync lies inside vblank
			check_val("stat during vsync", 3, rd[1:0]);
			while (!pix_en)
				@(posedge clk);
			wb_read(REG_STAT, rd);
			check_val("stat in picture", 0, rd[1:0]);
			while (frames < f0 + 2)
				@(posedge clk);
		end
		check_val("int while disabled", base, fall_cnt);

		$display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin : watchdog
		repeat (wd_clocks) @(posedge clk);
		$display("timeout, the test did not finish within %0d clocks", wd_clocks);
		$display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
design/video_pkg.sv
design/wb_regs.sv
design/sync_h.sv
design/sync_v.sv
design/video_out.sv
design/video_top.sv
sim/tb_video.sv

// File: run.sh
#!/bin/sh
# build and run the video timing testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_video -o tb_video
./obj_dir/tb_video | tee sim.log
# pass only if the testbench printed its pass line
grep -q "ALL TESTS PASSED" sim.log
echo "simulation passed"
